//--- design/mvp_defs.svh
// width and configuration limit macros for the mvp launch shell
`ifndef MVP_DEFS_SVH
`define MVP_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

// every launch configuration word
`define MVP_CFG_WIDTH       32
// byte sizes handed to the read engine
`define MVP_XFER_WIDTH      32
// write batch count
`define MVP_BATCH_WIDTH     15

//////////////////////////////////////////////////////////////////////
// configuration limits
//////////////////////////////////////////////////////////////////////

`define MVP_LEVEL_MAX       12
`define MVP_COL_MAX         16384
// row size times column size must reach this
`define MVP_MIN_COEFFS      8192
`define MVP_SPLIT_MAX       4
// index must be one-hot within these low bits
`define MVP_INDEX_BITS      13
`define MVP_MAT_LEN_BITS    15

// transfer sizing factors
`define MVP_MAT_UNIT_BYTES  32'h0001_8000
`define MVP_VEC_SPLIT_BYTES 32'h0003_0000

`endif

//--- design/mvp_pkg.sv
// package with command mode, run state, error flag and byte size types
`include "mvp_defs.svh"

package mvp_pkg;

    //////////////////////////////////////////////////////////////////////
    // command
    //////////////////////////////////////////////////////////////////////

    // opcode taken from bit 0 of the command word
    typedef enum logic {
        READ_ONLY = 1'b0,
        FULL_RUN  = 1'b1
    } cmd_mode_e;

    //////////////////////////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////////////////////////

    // phase sequencer states
    typedef enum logic [1:0] {
        RUN_IDLE  = 2'd0,
        RUN_READ  = 2'd1,
        RUN_WRITE = 2'd2
    } run_state_e;

    // launch check flags, level sits in bit 0
    typedef struct packed {
        logic mat_len;
        logic index;
        logic split;
        logic col_size;
        logic level;
    } cfg_err_t;

    // byte count for one transfer
    typedef logic [`MVP_XFER_WIDTH-1:0] xfer_bytes_t;

endpackage

//--- design/mvp_cfg_decode.sv
// start edge detection, five launch configuration checks and launch or reject pulse
`timescale 1ns/1ps
`include "mvp_defs.svh"

module mvp_cfg_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_ap_start,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_command,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_level,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_col_size,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_split,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_index,
    input  logic [`MVP_CFG_WIDTH-1:0]  i_mat_len,
    output mvp_pkg::cmd_mode_e         o_mode,
    output logic                       o_run_start,
    output logic                       o_cfg_reject,
    output mvp_pkg::cfg_err_t          o_cfg_err
);

    logic                       ap_start_q;
    logic                       start_pulse;
    logic                       start_pulse_q;
    logic [15:0]                row_size;
    logic [31:0]                coeff_cnt;
    logic [31:0]                mat_prod;
    logic [31:0]                split_prod;
    logic [`MVP_INDEX_BITS-1:0] index_low;
    logic                       index_onehot;
    mvp_pkg::cmd_mode_e         mode_in;
    mvp_pkg::cmd_mode_e         mode_q;
    mvp_pkg::cfg_err_t          err_next;
    mvp_pkg::cfg_err_t          err_q;

    //////////////////////////////////////////////////////////////////////
    // start edge
    //////////////////////////////////////////////////////////////////////

    assign start_pulse = i_ap_start & ~ap_start_q;
    assign mode_in     = mvp_pkg::cmd_mode_e'(i_command[0]);

    //////////////////////////////////////////////////////////////////////
    // configuration rules
    //////////////////////////////////////////////////////////////////////

    // row size is two to the level
    assign row_size   = 16'd1 << i_level[3:0];
    assign coeff_cnt  = {16'd0, row_size} * {17'd0, i_col_size[14:0]};
    assign index_low  = i_index[`MVP_INDEX_BITS-1:0];
    assign mat_prod   = {17'd0, i_mat_len[`MVP_MAT_LEN_BITS-1:0]} * {19'd0, index_low};
    assign split_prod = {29'd0, i_split[2:0]} * {16'd0, row_size};

    // x & (x-1) clears the lowest set bit
    assign index_onehot = (index_low != '0) && ((index_low & (index_low - 1'b1)) == '0);

    always_comb begin
        err_next = '0;
        // read-only launches skip every check
        if (mode_in == mvp_pkg::FULL_RUN) begin
            err_next.level    = (i_level == '0) || (i_level > `MVP_LEVEL_MAX);
            err_next.col_size = (i_col_size == '0) || (i_col_size > `MVP_COL_MAX) ||
                                (coeff_cnt < `MVP_MIN_COEFFS);
            err_next.split    = (i_split == '0) || (i_split > `MVP_SPLIT_MAX);
            err_next.index    = (i_index[`MVP_CFG_WIDTH-1:`MVP_INDEX_BITS] != '0) ||
                                !index_onehot;
            err_next.mat_len  = (i_mat_len[`MVP_CFG_WIDTH-1:`MVP_MAT_LEN_BITS] != '0) ||
                                (mat_prod != split_prod);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // launch registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_start_q    <= 1'b0;
            start_pulse_q <= 1'b0;
            mode_q        <= mvp_pkg::READ_ONLY;
            err_q         <= '0;
        end else begin
            ap_start_q    <= i_ap_start;
            start_pulse_q <= start_pulse;
            if (start_pulse) begin
                mode_q <= mode_in;
                err_q  <= err_next;
            end
        end
    end

    // exactly one of these fires, one cycle after the edge
    assign o_run_start  = start_pulse_q &&
                          ((mode_q == mvp_pkg::READ_ONLY) || (err_q == '0));
    assign o_cfg_reject = start_pulse_q && (mode_q == mvp_pkg::FULL_RUN) && (err_q != '0);

    assign o_mode    = mode_q;
    assign o_cfg_err = err_q;

endmodule

//--- design/mvp_run_exec.sv
// read and write phase sequencer with matrix, vector and batch size registers
`timescale 1ns/1ps
`include "mvp_defs.svh"

module mvp_run_exec (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_run_start,
    input  mvp_pkg::cmd_mode_e          i_mode,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_split,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_mat_len,
    input  logic                        i_rd_done,
    input  logic                        i_wr_done,
    output logic                        o_rd_start,
    output logic                        o_wr_start,
    output logic                        o_run_done,
    output mvp_pkg::xfer_bytes_t        o_mat_bytes,
    output mvp_pkg::xfer_bytes_t        o_vec_bytes,
    output logic [`MVP_BATCH_WIDTH-1:0] o_batches
);

    mvp_pkg::run_state_e         state_q;
    logic                        rd_start_q;
    logic                        wr_start_q;
    logic                        run_done_q;
    mvp_pkg::xfer_bytes_t        mat_bytes_q;
    mvp_pkg::xfer_bytes_t        vec_bytes_q;
    logic [`MVP_BATCH_WIDTH-1:0] batches_q;

    //////////////////////////////////////////////////////////////////////
    // phase sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= mvp_pkg::RUN_IDLE;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            run_done_q <= 1'b0;
        end else begin
            // start pulses and done are single cycle
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            run_done_q <= 1'b0;
            if (i_run_start) begin
                state_q    <= mvp_pkg::RUN_READ;
                rd_start_q <= 1'b1;
            end else begin
                case (state_q)
                    mvp_pkg::RUN_READ: begin
                        // engine may hold done low as long as it likes
                        if (i_rd_done) begin
                            if (i_mode == mvp_pkg::FULL_RUN) begin
                                state_q    <= mvp_pkg::RUN_WRITE;
                                wr_start_q <= 1'b1;
                            end else begin
                                state_q    <= mvp_pkg::RUN_IDLE;
                                run_done_q <= 1'b1;
                            end
                        end
                    end
                    mvp_pkg::RUN_WRITE: begin
                        if (i_wr_done) begin
                            state_q    <= mvp_pkg::RUN_IDLE;
                            run_done_q <= 1'b1;
                        end
                    end
                    default: begin
                        // stray done pulses land here and are dropped
                        state_q <= mvp_pkg::RUN_IDLE;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // transfer sizes
    //////////////////////////////////////////////////////////////////////

    // loaded once per launch, held for the engines
    always_ff @(posedge clk) begin
        if (i_run_start) begin
            mat_bytes_q <= `MVP_MAT_UNIT_BYTES * i_mat_len;
            vec_bytes_q <= `MVP_VEC_SPLIT_BYTES * {29'd0, i_split[2:0]};
            batches_q   <= i_mat_len[`MVP_MAT_LEN_BITS-1:1] + i_split[2:0];
        end
    end

    assign o_rd_start  = rd_start_q;
    assign o_wr_start  = wr_start_q;
    assign o_run_done  = run_done_q;
    assign o_mat_bytes = mat_bytes_q;
    assign o_vec_bytes = vec_bytes_q;
    assign o_batches   = batches_q;

endmodule

//--- design/mvp_status_result.sv
// done, idle and ready flags, ap_done status word and per-run cycle counter
`timescale 1ns/1ps

module mvp_status_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_run_start,
    input  logic              i_run_done,
    input  logic              i_cfg_reject,
    input  mvp_pkg::cfg_err_t i_cfg_err,
    output logic [31:0]       o_ap_done,
    output logic              o_ap_idle,
    output logic              o_ap_ready,
    output logic [31:0]       o_cycle_cnt
);

    logic        done_q;
    logic        idle_q;
    logic        finish;
    logic [31:0] cycle_q;

    // a rejected launch finishes as well
    assign finish = i_run_done | i_cfg_reject;

    //////////////////////////////////////////////////////////////////////
    // handshake flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
            idle_q <= 1'b1;
        end else if (i_run_start) begin
            done_q <= 1'b0;
            idle_q <= 1'b0;
        end else if (finish) begin
            done_q <= 1'b1;
            idle_q <= 1'b1;
        end
    end

    // cleared at launch, counts only while busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_q <= '0;
        end else if (i_run_start) begin
            cycle_q <= '0;
        end else if (!idle_q) begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    // status word: error flags at 12:8, done at 0
    assign o_ap_done   = {19'd0, i_cfg_err, 7'd0, done_q};
    assign o_ap_idle   = idle_q;
    assign o_ap_ready  = done_q;
    assign o_cycle_cnt = cycle_q;

endmodule

//--- design/mvp_top.sv
// top level of the mvp launch shell wiring decode, execute and result stages
`timescale 1ns/1ps
`include "mvp_defs.svh"

module mvp_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        i_ap_start,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_command,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_level,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_col_size,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_split,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_index,
    input  logic [`MVP_CFG_WIDTH-1:0]   i_mat_len,
    input  logic                        i_rd_done,
    input  logic                        i_wr_done,
    output logic [31:0]                 o_ap_done,
    output logic                        o_ap_idle,
    output logic                        o_ap_ready,
    output logic [31:0]                 o_cycle_cnt,
    output logic                        o_rd_start,
    output logic                        o_wr_start,
    output mvp_pkg::xfer_bytes_t        o_mat_bytes,
    output mvp_pkg::xfer_bytes_t        o_vec_bytes,
    output logic [`MVP_BATCH_WIDTH-1:0] o_batches
);

    mvp_pkg::cmd_mode_e mode;
    mvp_pkg::cfg_err_t  cfg_err;
    logic               run_start;
    logic               cfg_reject;
    logic               run_done;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    mvp_cfg_decode u_cfg_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ap_start   (i_ap_start),
        .i_command    (i_command),
        .i_level      (i_level),
        .i_col_size   (i_col_size),
        .i_split      (i_split),
        .i_index      (i_index),
        .i_mat_len    (i_mat_len),
        .o_mode       (mode),
        .o_run_start  (run_start),
        .o_cfg_reject (cfg_reject),
        .o_cfg_err    (cfg_err)
    );

    //////////////////////////////////////////////////////////////////////
    // execute
    //////////////////////////////////////////////////////////////////////

    mvp_run_exec u_run_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_run_start (run_start),
        .i_mode      (mode),
        .i_split     (i_split),
        .i_mat_len   (i_mat_len),
        .i_rd_done   (i_rd_done),
        .i_wr_done   (i_wr_done),
        .o_rd_start  (o_rd_start),
        .o_wr_start  (o_wr_start),
        .o_run_done  (run_done),
        .o_mat_bytes (o_mat_bytes),
        .o_vec_bytes (o_vec_bytes),
        .o_batches   (o_batches)
    );

    //////////////////////////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////////////////////////

    mvp_status_result u_status_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_run_start  (run_start),
        .i_run_done   (run_done),
        .i_cfg_reject (cfg_reject),
        .i_cfg_err    (cfg_err),
        .o_ap_done    (o_ap_done),
        .o_ap_idle    (o_ap_idle),
        .o_ap_ready   (o_ap_ready),
        .o_cycle_cnt  (o_cycle_cnt)
    );

endmodule

//--- tests/mvp_props.sv
// concurrent handshake assertions bound to the mvp top level
`timescale 1ns/1ps

module mvp_props (
    input logic        clk,
    input logic        rst_n,
    input logic        o_rd_start,
    input logic        o_wr_start,
    input logic        o_ap_idle,
    input logic        o_ap_ready
);

    // engine start pulses are single cycle
    rd_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        o_rd_start |=> !o_rd_start)
        else $error("o_rd_start held for more than one cycle");

    wr_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        o_wr_start |=> !o_wr_start)
        else $error("o_wr_start held for more than one cycle");

    // write phase only inside a busy run
    wr_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(o_wr_start) |-> !o_ap_idle)
        else $error("o_wr_start rose while idle");

    // launch has cleared ready and idle by the time the read engine starts
    rd_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        o_rd_start |-> !o_ap_ready && !o_ap_idle)
        else $error("o_rd_start while ready or idle still set");

endmodule

bind mvp_top mvp_props u_props (.*);

//--- tests/mvp_tb.sv
// testbench for mvp_top with file stimulus, engine models and compare tasks
`timescale 1ns/1ps
`include "mvp_defs.svh"

module mvp_tb;

    localparam int FIELDS  = 12;
    localparam int TIMEOUT = 500;

    logic clk, rst_n, i_ap_start, i_rd_done, i_wr_done;
    logic [31:0] i_command, i_level, i_col_size, i_split, i_index, i_mat_len;
    logic [31:0] o_ap_done, o_cycle_cnt;
    logic o_ap_idle, o_ap_ready, o_rd_start, o_wr_start;
    mvp_pkg::xfer_bytes_t o_mat_bytes, o_vec_bytes;
    logic [`MVP_BATCH_WIDTH-1:0] o_batches;

    logic [31:0] stim_mem [0:255];
    int rd_lat, wr_lat, rd_cnt, wr_cnt, mismatch_cnt, fail_cnt;
    logic rd_done_seen;

    mvp_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////
    // engine models and monitors
    ////////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (o_rd_start) begin
                rd_done_seen = 1'b0;
                repeat (rd_lat) @(posedge clk);
                #1 i_rd_done = 1'b1;
                rd_done_seen = 1'b1;
                @(posedge clk);
                #1 i_rd_done = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (o_wr_start) begin
                repeat (wr_lat) @(posedge clk);
                #1 i_wr_done = 1'b1;
                @(posedge clk);
                #1 i_wr_done = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (o_rd_start) rd_cnt++;
        if (o_wr_start) begin
            wr_cnt++;
            if (!rd_done_seen) begin
                $display("ERROR: write phase started before read done");
                fail_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic check_err(input string name, input mvp_pkg::cfg_err_t exp,
                             input mvp_pkg::cfg_err_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bytes(input string name, input mvp_pkg::xfer_bytes_t exp,
                               input mvp_pkg::xfer_bytes_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // launch helpers
    ////////////////////////////////////////////////////////////////////////

    // five cycles of reset so done starts out clear
    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic drive_cfg(input int base);
        @(posedge clk);
        #1;
        i_command  = stim_mem[base];
        i_level    = stim_mem[base+1];
        i_col_size = stim_mem[base+2];
        i_split    = stim_mem[base+3];
        i_index    = stim_mem[base+4];
        i_mat_len  = stim_mem[base+5];
        rd_lat     = stim_mem[base+6];
        wr_lat     = stim_mem[base+7];
        i_ap_start = 1'b1;
    endtask

    // busy phase first when the launch should start a run
    task automatic wait_run_done(input string name, input logic go_busy);
        int t;
        t = 0;
        while (go_busy && o_ap_idle !== 1'b0 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: %s never left idle", name);
            fail_cnt++;
        end
        t = 0;
        while (o_ap_done[0] !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (t >= TIMEOUT) begin
            $display("ERROR: %s never signalled done", name);
            fail_cnt++;
        end
    endtask

    task automatic run_line(input int n);
        int base, rd0, wr0;
        string name;
        logic full, reject;
        logic [31:0] cnt;
        base   = n * FIELDS;
        name   = $sformatf("launch%0d", n);
        full   = stim_mem[base][0];
        reject = (stim_mem[base+8] != 0);
        if (reject) begin
            // a rejected launch leaves done set, so clear it first
            apply_reset();
        end
        rd0    = rd_cnt;
        wr0    = wr_cnt;
        drive_cfg(base);
        wait_run_done(name, !reject);
        check_bit({name, " done"}, 1'b1, o_ap_done[0]);
        check_bit({name, " ready"}, 1'b1, o_ap_ready);
        check_bit({name, " idle"}, 1'b1, o_ap_idle);
        check_err({name, " err"}, mvp_pkg::cfg_err_t'(stim_mem[base+8][4:0]),
                  mvp_pkg::cfg_err_t'(o_ap_done[12:8]));
        check_word({name, " rd starts"}, reject ? 0 : 1, rd_cnt - rd0);
        check_word({name, " wr starts"}, (full && !reject) ? 1 : 0, wr_cnt - wr0);
        if (!reject) begin
            check_bytes({name, " mat bytes"}, stim_mem[base+9], o_mat_bytes);
            check_bytes({name, " vec bytes"}, stim_mem[base+10], o_vec_bytes);
            check_word({name, " batches"}, stim_mem[base+11], {17'd0, o_batches});
        end
        if (full && !reject) begin
            if (o_cycle_cnt <= rd_lat + wr_lat) begin
                $display("ERROR: %s cycle count %0d too small", name, o_cycle_cnt);
                fail_cnt++;
            end
            cnt = o_cycle_cnt;
            repeat (3) @(negedge clk);
            check_word({name, " idle count"}, cnt, o_cycle_cnt);
        end
        @(posedge clk);
        #1 i_ap_start = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        int n, rd0;
        {i_ap_start, i_rd_done, i_wr_done} = '0;
        {i_command, i_level, i_col_size, i_split, i_index, i_mat_len} = '0;
        {rd_lat, wr_lat, rd_cnt, wr_cnt, mismatch_cnt, fail_cnt} = '0;
        rd_done_seen = 1'b0;
        $readmemh("tests/mvp_stim.txt", stim_mem);
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset idle", 1'b1, o_ap_idle);
        check_word("reset done", 32'd0, o_ap_done);
        check_bit("reset rd_start", 1'b0, o_rd_start);
        check_bit("reset wr_start", 1'b0, o_wr_start);

        n = 0;
        while (!$isunknown(stim_mem[n*FIELDS]) && stim_mem[n*FIELDS] != 32'hffff_ffff) begin
            run_line(n);
            n++;
        end

        // start held high gives one launch only
        rd0 = rd_cnt;
        drive_cfg(0);
        wait_run_done("held start", 1'b1);
        repeat (6) @(negedge clk);
        check_word("held start launches", 1, rd_cnt - rd0);
        check_bit("held start idle", 1'b1, o_ap_idle);
        @(posedge clk);
        #1 i_ap_start = 1'b0;
        drive_cfg(0);
        wait_run_done("relaunch busy", 1'b1);
        check_word("relaunch launches", 2, rd_cnt - rd0);
        @(posedge clk);
        #1 i_ap_start = 1'b0;

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // ready must drop once the relaunch goes busy
    always @(negedge clk) begin
        if (rst_n && !o_ap_idle && o_ap_ready) begin
            $display("ERROR: ready still set while a run is busy");
            fail_cnt++;
        end
    end

    initial begin
        #200us;
        $display("ERROR: simulation time limit reached");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- mvp_top.f
+incdir+design
design/mvp_pkg.sv
design/mvp_cfg_decode.sv
design/mvp_run_exec.sv
design/mvp_status_result.sv
design/mvp_top.sv
tests/mvp_props.sv
tests/mvp_tb.sv

//--- Bender.yml
package:
  name: mvp_top

sources:
  - include_dirs:
      - design
    files:
      - design/mvp_pkg.sv
      - design/mvp_cfg_decode.sv
      - design/mvp_run_exec.sv
      - design/mvp_status_result.sv
      - design/mvp_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/mvp_props.sv
      - tests/mvp_tb.sv

//--- tests/mvp_stim.txt
// one launch per line, all hex: command level col_size split index mat_len
// rd_lat wr_lat exp_err exp_mat_bytes exp_vec_bytes exp_batches, last line ends
// valid full run
00000001 0000000c 00000002 00000004 00000001 00004000 00000005 00000007 00 60000000 000c0000 2004
// read-only with illegal configuration
00000000 00000000 00000000 00000003 00000000 0000000a 00000004 00000000 00 000f0000 00090000 0008
// level too high
00000001 0000000d 00000002 00000004 00000002 00004000 00000000 00000000 01 00000000 00000000 0000
// column size too large
00000001 0000000c 00004001 00000004 00000001 00004000 00000000 00000000 02 00000000 00000000 0000
// split too large
00000001 0000000c 00000002 00000005 00000001 00005000 00000000 00000000 04 00000000 00000000 0000
// index not one-hot
00000001 0000000c 00000002 00000003 00000003 00001000 00000000 00000000 08 00000000 00000000 0000
// matrix length mismatch
00000001 0000000c 00000002 00000004 00000001 00002000 00000000 00000000 10 00000000 00000000 0000
// full run with slow write engine
00000001 0000000c 00000002 00000004 00000001 00004000 00000003 00000014 00 60000000 000c0000 2004
// end marker
ffffffff
